/* hw/rvDecodePkg.sv */
package rvDecodePkg;

    // Basic field types
    typedef logic [31:0] instrT;
    typedef logic [6:0]  opcodeT;
    typedef logic [4:0]  regIdxT;

    // Immediate formats, J and U kept apart
    typedef logic [2:0] immSrcT;
    localparam immSrcT IMM_I = 3'd0;
    localparam immSrcT IMM_S = 3'd1;
    localparam immSrcT IMM_B = 3'd2;
    localparam immSrcT IMM_J = 3'd3;
    localparam immSrcT IMM_U = 3'd4;

    // Load/store size, same encoding as funct3
    typedef logic [2:0] sizeT;
    localparam sizeT SIZE_B  = 3'b000;
    localparam sizeT SIZE_H  = 3'b001;
    localparam sizeT SIZE_W  = 3'b010;
    localparam sizeT SIZE_BU = 3'b100;
    localparam sizeT SIZE_HU = 3'b101;

    // ALU operation class from the main decoder
    typedef logic [1:0] aluOpT;
    localparam aluOpT ALUOP_ADD    = 2'b00; // Address and jump targets
    localparam aluOpT ALUOP_BRANCH = 2'b01; // Branch compare
    localparam aluOpT ALUOP_FUNC   = 2'b10; // Look at funct3/funct7
    localparam aluOpT ALUOP_UPPER  = 2'b11; // LUI and AUIPC

    // Writeback source
    typedef logic [1:0] resultSrcT;
    localparam resultSrcT RES_ALU = 2'b00;
    localparam resultSrcT RES_MEM = 2'b01;
    localparam resultSrcT RES_PC4 = 2'b10;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_AND   = 4'd2,
        ALU_OR    = 4'd3,
        ALU_XOR   = 4'd4,
        ALU_SLL   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_SLT   = 4'd8,
        ALU_SLTU  = 4'd9,
        ALU_PASSB = 4'd10  // Immediate straight through
    } aluCtrlT;

    // RV32I base opcodes
    localparam opcodeT OP_JAL    = 7'b1101111;
    localparam opcodeT OP_JALR   = 7'b1100111;
    localparam opcodeT OP_BRANCH = 7'b1100011;
    localparam opcodeT OP_LOAD   = 7'b0000011;
    localparam opcodeT OP_STORE  = 7'b0100011;
    localparam opcodeT OP_IMM    = 7'b0010011;
    localparam opcodeT OP_REG    = 7'b0110011;
    localparam opcodeT OP_LUI    = 7'b0110111;
    localparam opcodeT OP_AUIPC  = 7'b0010111;

endpackage

/* hw/mainDecoder.sv */
`timescale 1ns/1ps

module mainDecoder
    import rvDecodePkg::*;
(
    input  opcodeT     op,
    input  logic [2:0] funct3,
    output logic       regWrite,
    output logic       memWrite,
    output logic       aluSrc,
    output logic       branch,
    output logic       jumpSrc,
    output logic       jalrSrc,
    output resultSrcT  resultSrc,
    output immSrcT     immSrc,
    output aluOpT      aluOp,
    output sizeT       sizeSrc,
    output logic       illegal
);

    always_comb begin
        regWrite  = 1'b0;
        memWrite  = 1'b0;
        aluSrc    = 1'b0;
        branch    = 1'b0;
        jumpSrc   = 1'b0;
        jalrSrc   = 1'b0;
        resultSrc = RES_ALU;
        immSrc    = IMM_I;
        aluOp     = ALUOP_ADD;
        sizeSrc   = SIZE_B;
        illegal   = 1'b0;

        case (op)
            OP_JAL: begin
                regWrite  = 1'b1;
                immSrc    = IMM_J;
                aluSrc    = 1'b1;
                resultSrc = RES_PC4;   // Link address
                jumpSrc   = 1'b1;
            end

            OP_JALR: begin
                regWrite  = 1'b1;
                aluSrc    = 1'b1;
                resultSrc = RES_PC4;
                jumpSrc   = 1'b1;
                jalrSrc   = 1'b1;      // Target from rs1 + imm
            end

            OP_BRANCH: begin
                branch = 1'b1;
                immSrc = IMM_B;
                aluOp  = ALUOP_BRANCH;
            end

            OP_LOAD: begin
                regWrite  = 1'b1;
                aluSrc    = 1'b1;
                resultSrc = RES_MEM;
                case (funct3)
                    SIZE_B, SIZE_H, SIZE_W, SIZE_BU, SIZE_HU: sizeSrc = funct3;
                    default: illegal = 1'b1;
                endcase
            end

            OP_STORE: begin
                memWrite = 1'b1;
                immSrc   = IMM_S;
                aluSrc   = 1'b1;
                case (funct3)
                    SIZE_B, SIZE_H, SIZE_W: sizeSrc = funct3;
                    default: illegal = 1'b1;   // No unsigned stores
                endcase
            end

            OP_IMM: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = ALUOP_FUNC;
            end

            OP_REG: begin
                regWrite = 1'b1;
                aluOp    = ALUOP_FUNC;
            end

            // aluDecoder tells these two apart by opcode bit 5
            OP_LUI, OP_AUIPC: begin
                regWrite = 1'b1;
                immSrc   = IMM_U;
                aluSrc   = 1'b1;
                aluOp    = ALUOP_UPPER;
            end

            default: illegal = 1'b1;
        endcase

        // Illegal encodings leave a clean control word
        if (illegal) begin
            regWrite  = 1'b0;
            memWrite  = 1'b0;
            aluSrc    = 1'b0;
            branch    = 1'b0;
            jumpSrc   = 1'b0;
            jalrSrc   = 1'b0;
            resultSrc = RES_ALU;
            immSrc    = IMM_I;
            aluOp     = ALUOP_ADD;
            sizeSrc   = SIZE_B;
        end
    end

endmodule

/* hw/aluDecoder.sv */
`timescale 1ns/1ps

module aluDecoder
    import rvDecodePkg::*;
(
    input  aluOpT      aluOp,
    input  logic [2:0] funct3,
    input  logic       funct7b5,
    input  logic       opb5,       // Set for R-type and LUI
    output aluCtrlT    aluControl
);

    logic isSub;

    // Only R-type uses funct7b5 for subtract, ADDI has imm bits there
    assign isSub = opb5 & funct7b5;

    always_comb begin
        aluControl = ALU_ADD;

        case (aluOp)
            ALUOP_ADD:    aluControl = ALU_ADD;
            ALUOP_BRANCH: aluControl = ALU_SUB;   // Compare by subtract

            ALUOP_FUNC: begin
                case (funct3)
                    3'b000:  aluControl = isSub ? ALU_SUB : ALU_ADD;
                    3'b001:  aluControl = ALU_SLL;
                    3'b010:  aluControl = ALU_SLT;
                    3'b011:  aluControl = ALU_SLTU;
                    3'b100:  aluControl = ALU_XOR;
                    3'b101:  aluControl = funct7b5 ? ALU_SRA : ALU_SRL;  // Also valid for SRAI
                    3'b110:  aluControl = ALU_OR;
                    default: aluControl = ALU_AND;
                endcase
            end

            // LUI passes the immediate, AUIPC adds it to the PC
            default: aluControl = opb5 ? ALU_PASSB : ALU_ADD;
        endcase
    end

endmodule

/* hw/immExtend.sv */
`timescale 1ns/1ps

module immExtend
    import rvDecodePkg::*;
#(
    parameter int XLEN = 32
) (
    input  instrT             instr,
    input  immSrcT            immSrc,
    output logic [XLEN-1:0]   immExt
);

    logic signed [31:0] imm32;

    always_comb begin
        case (immSrc)
            IMM_I: imm32 = {{20{instr[31]}}, instr[31:20]};
            IMM_S: imm32 = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            // Branch offsets are even
            IMM_B: imm32 = {{20{instr[31]}}, instr[7], instr[30:25],
                            instr[11:8], 1'b0};
            IMM_J: imm32 = {{12{instr[31]}}, instr[19:12], instr[20],
                            instr[30:21], 1'b0};
            IMM_U: imm32 = {instr[31:12], 12'b0};   // Upper 20 bits
            default: imm32 = '0;
        endcase
    end

    // Sign extension past 32 bits on wider cores
    assign immExt = XLEN'(imm32);

endmodule

/* hw/decodeSkidBuffer.sv */
`timescale 1ns/1ps

module decodeSkidBuffer #(
    parameter int WIDTH = 63
) (
    input  logic             clk,
    input  logic             arstN,
    input  logic             inValid,
    output logic             inReady,
    input  logic [WIDTH-1:0] inData,
    output logic             outValid,
    input  logic             outReady,
    output logic [WIDTH-1:0] outData
);

    logic             mainValid;
    logic             skidValid;
    logic [WIDTH-1:0] mainData;
    logic [WIDTH-1:0] skidData;
    logic             inFire;
    logic             mainFree;  // Main entry can load this cycle

    assign inReady  = ~skidValid;   // Straight from a flop
    assign inFire   = inValid & inReady;
    assign mainFree = ~mainValid | outReady;

    assign outValid = mainValid;
    assign outData  = mainData;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mainValid <= 1'b0;
            skidValid <= 1'b0;
        end else if (mainFree) begin
            // Skid drains first, input is blocked while it is full
            mainValid <= skidValid | inFire;
            skidValid <= 1'b0;
        end else if (inFire) begin
            skidValid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mainFree) begin
            if (skidValid) begin
                mainData <= skidData;
            end else if (inFire) begin
                mainData <= inData;
            end
        end else if (inFire) begin
            skidData <= inData;   // Main is stalled
        end
    end

endmodule

/* hw/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage
    import rvDecodePkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            arstN,
    input  logic            instrValid,
    output logic            instrReady,
    input  instrT           instr,
    output logic            decValid,
    input  logic            decReady,
    output logic            regWrite,
    output logic            memWrite,
    output logic            aluSrc,
    output resultSrcT       resultSrc,
    output logic            branch,
    output logic            jumpSrc,
    output logic            jalrSrc,
    output sizeT            sizeSrc,
    output aluCtrlT         aluControl,
    output logic [XLEN-1:0] immExt,
    output regIdxT          rs1,
    output regIdxT          rs2,
    output regIdxT          rd,
    output logic            illegal
);

    // Seven single-bit flags plus the typed fields
    localparam int WIDTH = 7 + $bits(resultSrcT) + $bits(sizeT) + $bits(aluCtrlT)
                         + 3 * $bits(regIdxT) + XLEN;

    logic             dRegWrite, dMemWrite, dAluSrc, dBranch;
    logic             dJumpSrc, dJalrSrc, dIllegal;
    resultSrcT        dResultSrc;
    immSrcT           dImmSrc;
    aluOpT            dAluOp;
    sizeT             dSizeSrc;
    aluCtrlT          dAluControl;
    logic [XLEN-1:0]  dImmExt;
    logic [3:0]       aluCtrlBits;
    logic [WIDTH-1:0] inBundle;
    logic [WIDTH-1:0] outBundle;

    mainDecoder u_mainDecoder (
        .op        (instr[6:0]),
        .funct3    (instr[14:12]),
        .regWrite  (dRegWrite),
        .memWrite  (dMemWrite),
        .aluSrc    (dAluSrc),
        .branch    (dBranch),
        .jumpSrc   (dJumpSrc),
        .jalrSrc   (dJalrSrc),
        .resultSrc (dResultSrc),
        .immSrc    (dImmSrc),
        .aluOp     (dAluOp),
        .sizeSrc   (dSizeSrc),
        .illegal   (dIllegal)
    );

    aluDecoder u_aluDecoder (
        .aluOp      (dAluOp),
        .funct3     (instr[14:12]),
        .funct7b5   (instr[30]),
        .opb5       (instr[5]),
        .aluControl (dAluControl)
    );

    immExtend #(.XLEN(XLEN)) u_immExtend (
        .instr  (instr),
        .immSrc (dImmSrc),
        .immExt (dImmExt)
    );

    // Register indices come straight from the instruction fields
    assign inBundle = {dRegWrite, dMemWrite, dAluSrc, dResultSrc, dBranch, dJumpSrc,
                       dJalrSrc, dSizeSrc, dAluControl, dImmExt, instr[19:15],
                       instr[24:20], instr[11:7], dIllegal};

    decodeSkidBuffer #(.WIDTH(WIDTH)) u_decodeSkidBuffer (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (instrValid),
        .inReady  (instrReady),
        .inData   (inBundle),
        .outValid (decValid),
        .outReady (decReady),
        .outData  (outBundle)
    );

    assign {regWrite, memWrite, aluSrc, resultSrc, branch, jumpSrc, jalrSrc, sizeSrc,
            aluCtrlBits, immExt, rs1, rs2, rd, illegal} = outBundle;

    assign aluControl = aluCtrlT'(aluCtrlBits);  // Back to the enum

endmodule

/* verif/tbClock.sv */
`timescale 1ns/1ps

module tbClock #(
    parameter int PERIOD_NS   = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        arstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);  // Release away from the active edge
        arstN = 1'b1;
    end

endmodule

/* verif/decodeStageTb.sv */
`timescale 1ns/1ps

module decodeStageTb
    import rvDecodePkg::*;
;

    localparam int XLEN    = 32;
    localparam int MAX_VEC = 64;
    localparam int FIELDS  = 9;   // Tokens per vector line

    logic            clk;
    logic            arstN;
    logic            instrValid;
    logic            instrReady;
    instrT           instr;
    logic            decValid;
    logic            decReady;
    logic            regWrite, memWrite, aluSrc, branch;
    logic            jumpSrc, jalrSrc, illegal;
    resultSrcT       resultSrc;
    sizeT            sizeSrc;
    aluCtrlT         aluControl;
    logic [XLEN-1:0] immExt;
    regIdxT          rs1, rs2, rd;

    logic [31:0] stimMem [0:FIELDS*MAX_VEC-1];
    int          acceptCycle [0:2*MAX_VEC-1];
    int          numVec;
    int          errorCount;
    int          checkCount;
    int          seed;

    tbClock #(.PERIOD_NS(20), .RESET_CYCLES(10)) u_tbClock (
        .clk   (clk),
        .arstN (arstN)
    );

    decodeStage #(.XLEN(XLEN)) u_decodeStage (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instrReady (instrReady),
        .instr      (instr),
        .decValid   (decValid),
        .decReady   (decReady),
        .regWrite   (regWrite),
        .memWrite   (memWrite),
        .aluSrc     (aluSrc),
        .resultSrc  (resultSrc),
        .branch     (branch),
        .jumpSrc    (jumpSrc),
        .jalrSrc    (jalrSrc),
        .sizeSrc    (sizeSrc),
        .aluControl (aluControl),
        .immExt     (immExt),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .illegal    (illegal)
    );

    task automatic checkCtrl(input string name, input logic exp, input logic act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("error %s: expected %0b, actual %0b", name, exp, act);
        end
    endtask

    task automatic checkResult(input string name, input resultSrcT exp, input resultSrcT act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("error %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic checkSize(input string name, input sizeT exp, input sizeT act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("error %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic checkAlu(input string name, input aluCtrlT exp, input aluCtrlT act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("error %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic checkImm(input string name, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic checkReg(input string name, input regIdxT exp, input regIdxT act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("error %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic checkLatency(input string name, input int exp, input int act);
        checkCount++;
        if (act != exp) begin
            errorCount++;
            $display("error %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    function automatic logic randBit();
        int r;
        r = $random(seed);
        return r[0];
    endfunction

    // Compare the bundle on the outputs with vector idx
    task automatic compareBundle(input int idx);
        int          base;
        logic [6:0]  ctrl;
        string       tag;
        base = FIELDS * idx;
        ctrl = stimMem[base+1][6:0];
        tag  = $sformatf("vec %0d (%h)", idx, stimMem[base]);
        checkCtrl({tag, " regWrite"}, ctrl[6], regWrite);
        checkCtrl({tag, " memWrite"}, ctrl[5], memWrite);
        checkCtrl({tag, " aluSrc"},   ctrl[4], aluSrc);
        checkCtrl({tag, " branch"},   ctrl[3], branch);
        checkCtrl({tag, " jumpSrc"},  ctrl[2], jumpSrc);
        checkCtrl({tag, " jalrSrc"},  ctrl[1], jalrSrc);
        checkCtrl({tag, " illegal"},  ctrl[0], illegal);
        checkResult({tag, " resultSrc"}, resultSrcT'(stimMem[base+2][1:0]), resultSrc);
        checkSize({tag, " sizeSrc"}, sizeT'(stimMem[base+3][2:0]), sizeSrc);
        checkAlu({tag, " aluControl"}, aluCtrlT'(stimMem[base+4][3:0]), aluControl);
        checkImm({tag, " immExt"}, stimMem[base+5], immExt);
        checkReg({tag, " rs1"}, regIdxT'(stimMem[base+6][4:0]), rs1);
        checkReg({tag, " rs2"}, regIdxT'(stimMem[base+7][4:0]), rs2);
        checkReg({tag, " rd"},  regIdxT'(stimMem[base+8][4:0]), rd);
    endtask

    initial begin
        int   cycle;
        int   sendCount;
        int   recvCount;
        int   total;
        logic holding;   // Offered word not yet taken
        instrValid = 1'b0;
        instr      = '0;
        decReady   = 1'b0;
        errorCount = 0;
        checkCount = 0;
        seed       = 96531;
        numVec     = 0;
        $readmemh("verif/decode_stim.txt", stimMem);
        // Terminator line has all ones in the control column
        while (numVec < MAX_VEC && stimMem[FIELDS*numVec+1] != 32'hffffffff) begin
            numVec++;
        end
        if (numVec == 0 || numVec == MAX_VEC) begin
            $display("Stimulus file missing or without end marker");
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            total = 2 * numVec;   // Full-rate pass, then random pass
            @(posedge arstN);
            @(negedge clk);
            checkCtrl("reset decValid", 1'b0, decValid);
            checkCtrl("reset instrReady", 1'b1, instrReady);

            cycle     = 0;
            sendCount = 0;
            recvCount = 0;
            holding   = 1'b0;
            while (recvCount < total) begin
                @(negedge clk);
                cycle++;
                decReady = (recvCount < numVec) ? 1'b1 : randBit();
                if (decValid && decReady) begin
                    compareBundle(recvCount % numVec);
                    if (recvCount < numVec) begin
                        checkLatency($sformatf("vec %0d latency", recvCount), 1,
                                     cycle - acceptCycle[recvCount]);
                    end
                    recvCount++;
                end

                if (!holding) begin
                    if (sendCount < total) begin
                        instrValid = (sendCount < numVec) ? 1'b1 : (randBit() | randBit());
                        instr      = stimMem[FIELDS*(sendCount % numVec)];
                    end else begin
                        instrValid = 1'b0;
                    end
                end
                if (sendCount < numVec && instrValid && !instrReady) begin
                    errorCount++;
                    $display("instrReady dropped during the full-rate pass at cycle %0d",
                             cycle);
                end
                if (instrValid && instrReady) begin
                    acceptCycle[sendCount] = cycle;
                    sendCount++;
                    holding = 1'b0;
                end else begin
                    holding = instrValid;
                end
            end

            // Nothing more may come out
            instrValid = 1'b0;
            decReady   = 1'b1;
            repeat (3) begin
                @(negedge clk);
                if (decValid) begin
                    errorCount++;
                    $display("Extra bundle delivered after all vectors were received");
                end
            end

            $display("Vectors: %0d, checks: %0d, errors: %0d", numVec, checkCount, errorCount);
            if (errorCount == 0) begin
                $display("TEST RESULT: PASS");
            end else begin
                $display("TEST RESULT: FAIL");
            end
            $finish;
        end
    end

    // Watchdog sized from the vector count
    initial begin
        #1;
        repeat (40 * numVec + 20) @(posedge clk);
        $display("Timeout, the DUT did not deliver all bundles");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* verif/decode_stim.txt */
// instr ctrl{rw,mw,aluSrc,br,jmp,jalr,ill} resultSrc size aluCtrl immExt rs1 rs2 rd
// one instruction per line, all values in hex
00500093 50 0 0 0 00000005 00 05 01  // addi x1,x0,5
fff08113 50 0 0 0 ffffffff 01 1f 02  // addi x2,x1,-1
002081b3 40 0 0 0 00000002 01 02 03  // add
40208233 40 0 0 1 00000402 01 02 04  // sub
4020d2b3 40 0 0 7 00000402 01 02 05  // sra
0020d2b3 40 0 0 6 00000002 01 02 05  // srl
4030d313 50 0 0 7 00000403 01 03 06  // srai
8000c393 50 0 0 4 fffff800 01 00 07  // xori -2048
0020e433 40 0 0 3 00000002 01 02 08  // or
0020f4b3 40 0 0 2 00000002 01 02 09  // and
0020a533 40 0 0 8 00000002 01 02 0a  // slt
0020b5b3 40 0 0 9 00000002 01 02 0b  // sltu
00209633 40 0 0 5 00000002 01 02 0c  // sll
00812683 50 1 2 0 00000008 02 08 0d  // lw
ffc14703 50 1 4 0 fffffffc 02 1c 0e  // lbu -4
00215783 50 1 5 0 00000002 02 02 0f  // lhu
00013083 01 0 0 0 00000000 02 00 01  // load funct3 3
00016083 01 0 0 0 00000000 02 00 01  // load funct3 6
0020a623 30 0 2 0 0000000c 01 02 0c  // sw
fe308fa3 30 0 0 0 ffffffff 01 03 1f  // sb -1
00419323 30 0 1 0 00000006 03 04 06  // sh
0020b023 01 0 0 0 00000002 01 02 00  // store funct3 3
fe208ce3 08 0 0 1 fffffff8 01 02 19  // beq -8
00209863 08 0 0 1 00000010 01 02 10  // bne +16
001000ef 54 2 0 0 00000800 00 01 01  // jal +2048
ffdff06f 54 2 0 0 fffffffc 1f 1d 00  // jal -4
004280e7 56 2 0 0 00000004 05 04 01  // jalr
800002b7 50 0 0 a 80000000 00 00 05  // lui
12345317 50 0 0 0 12345000 08 03 06  // auipc
0000000f 01 0 0 0 00000000 00 00 00  // fence, not supported
00000000 01 0 0 0 00000000 00 00 00  // all zero word
ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff

/* all.f */
hw/rvDecodePkg.sv
hw/mainDecoder.sv
hw/aluDecoder.sv
hw/immExtend.sv
hw/decodeSkidBuffer.sv
hw/decodeStage.sv
verif/tbClock.sv
verif/decodeStageTb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -f all.f --top-module decodeStageTb -o simv
	./obj_dir/simv | tee sim.log
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
